/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rvfi_mem_monitor_tb
RTL_TOP  = rvfi_mem_monitor
FILELIST = src.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* src.f */
verilog/obi_pkg.sv
verilog/rvfi_pkg.sv
verilog/obi_xfer_fifo.sv
verilog/rvfi_mem_expect.sv
verilog/rvfi_mem_compare.sv
verilog/rvfi_mem_monitor.sv
test/rvfi_mem_monitor_chk.sv
test/rvfi_mem_monitor_tb.sv

/* test/mem_input.txt */
// Per test: {id, transfers, stall cycles, expected flags} and the trap word
// then transfers 0-1, transfers 2-3 (addr ctrl wdata rdata), RVFI ops 0-1
// (addr ctrl rdata wdata); flags are addr mask rdata wdata prot memtype dbg
01010000 00000000
00000100 000007b0 00000000 deadbeef 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000100 00003c18 deadbeef 00000000 00000000 00000000 00000000 00000000
02010000 00000000
00000202 00000201 00ab0000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000202 00000040 00000000 000000ab 00000000 00000000 00000000 00000000
03010008 00000000
00000300 00000781 11223344 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000300 000003c0 00000000 11223355 00000000 00000000 00000000 00000000
04010000 00000000
00000304 00000181 0000beef 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000304 000000c0 00000000 1234beef 00000000 00000000 00000000 00000000
05020000 00000000
00000403 00000400 00000000 aa000000 00000404 00000080 00000000 000000bb
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000403 00000c00 0000bbaa 00000000 00000000 00000000 00000000 00000000
06020020 00000000
00000403 00000400 00000000 aa000000 00000404 00000080 00000000 000000bb
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000403 00001c00 0000bbaa 00000000 00000000 00000000 00000000 00000000
07040000 00000000
00000501 00000700 00000000 33221100 00000504 00000080 00000000 00000044
00000509 00000700 00000000 77665500 0000050c 00000080 00000000 00000088
00000501 00003c00 44332211 00000000 00000509 00003c00 88776655 00000000
08010000 00000000
00000600 00000780 00000000 cafef00d 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000600 00003c00 cafef00d 00000000 00000000 00000000 00000000 00000000
09010000 00000c50
00000700 00000780 00000000 12345678 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000700 00003c00 87654321 00000000 00000000 00000000 00000000 00000000
0a010400 00000000
00000800 00000781 aaaa5555 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000800 000003c0 00000000 5555aaaa 00000000 00000000 00000000 00000000

/* test/rvfi_mem_monitor_chk.sv */
// RVFI memory monitor checker
// Bound into the compare stage to watch the error flags and the checked
// pulse for sanity during reset and in normal operation
module rvfi_mem_monitor_chk (
  input logic                clk_i,
  input logic                rst_ni,
  input rvfi_pkg::rvfi_mem_t i_rvfi_dly,
  input rvfi_pkg::mem_err_t  i_err,
  input logic                i_checked
);
  timeunit 1ns;
  timeprecision 100ps;

  logic has_op;

  // The delayed record moved data when any of its masks has a byte set
  always_comb begin
    has_op = 1'b0;
    for (int i = 0; i < rvfi_pkg::NMEM; i++) begin
      has_op = has_op || (|i_rvfi_dly.op[i].rmask) || (|i_rvfi_dly.op[i].wmask);
    end
    has_op = has_op && i_rvfi_dly.valid;
  end

  // Flags only ever come together with a checked pulse
  err_needs_checked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !i_checked |-> (i_err == '0))
    else $error("error flags set without a checked pulse");

  // Reset keeps both outputs quiet
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!i_checked && (i_err == '0)))
    else $error("outputs active during reset");

  // Every delayed record with a transfer is checked one cycle later
  checked_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    has_op |=> i_checked)
    else $error("delayed record was not checked");

endmodule

/* test/rvfi_mem_monitor_tb.sv */
// RVFI memory monitor testbench
// Replays OBI transfers and RVFI records from a data file, waits for the
// checked pulse and compares the error flags with the expected ones
module rvfi_mem_monitor_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NTEST = 10;
  // Words per test: header, trap, four transfers and two operations
  localparam int WPT   = 26;

  logic                clk_i;
  logic                rst_ni;
  logic                obi_req;
  logic                obi_gnt;
  logic                obi_rvalid;
  obi_pkg::obi_req_t   obi_payload;
  logic [31:0]         obi_rdata;
  rvfi_pkg::rvfi_mem_t rvfi;
  rvfi_pkg::mem_err_t  err;
  logic                checked;

  logic [31:0]         words [NTEST*WPT];
  logic                seen;
  rvfi_pkg::mem_err_t  seen_err;
  logic                stop_run;
  int                  n_pass;
  int                  n_fail;

  rvfi_mem_monitor UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_obi_req     (obi_req),
    .i_obi_gnt     (obi_gnt),
    .i_obi_rvalid  (obi_rvalid),
    .i_obi_payload (obi_payload),
    .i_obi_rdata   (obi_rdata),
    .i_rvfi        (rvfi),
    .o_err         (err),
    .o_checked     (checked)
  );

  bind rvfi_mem_compare rvfi_mem_monitor_chk u_chk (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .i_rvfi_dly (i_rvfi_dly),
    .i_err      (o_err),
    .i_checked  (o_checked)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Outputs change on the rising edge and are captured on the falling one
  always @(negedge clk_i) begin
    if (checked) begin
      seen     = 1'b1;
      seen_err = err;
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Transfer words are address, control, write data and read data
  function automatic obi_pkg::obi_req_t unpack_xfer(input int w);
    obi_pkg::obi_req_t p;
    logic [31:0]       c;
    c         = words[w+1];
    p.addr    = words[w];
    p.be      = c[10:7];
    p.prot    = c[6:4];
    p.memtype = c[3:2];
    p.dbg     = c[1];
    p.we      = c[0];
    p.wdata   = words[w+2];
    return p;
  endfunction

  // Record from the trap word and the two operation blocks
  function automatic rvfi_pkg::rvfi_mem_t decode_rvfi(input int base);
    rvfi_pkg::rvfi_mem_t r;
    logic [31:0]         t;
    logic [31:0]         c;
    t     = words[base+1];
    r     = '0;
    r.valid                 = 1'b1;
    r.trap.trap             = t[11];
    r.trap.exception        = t[10];
    r.trap.exception_cause  = t[9:4];
    r.trap.debug            = t[3];
    r.trap.debug_cause      = t[2:0];
    for (int i = 0; i < rvfi_pkg::NMEM; i++) begin
      c                  = words[base+18+4*i+1];
      r.op[i].addr       = words[base+18+4*i];
      r.op[i].rmask      = c[13:10];
      r.op[i].wmask      = c[9:6];
      r.op[i].prot       = c[5:3];
      r.op[i].memtype    = c[2:1];
      r.op[i].dbg        = c[0];
      r.op[i].rdata      = words[base+18+4*i+2];
      r.op[i].wdata      = words[base+18+4*i+3];
    end
    return r;
  endfunction

  // Poll the captured pulse with a bound on the number of cycles
  task automatic wait_checked(input int t, output logic found);
    int n;
    n = 0;
    while (!seen && n < 20) begin
      @(posedge clk_i);
      n++;
    end
    found = seen;
    if (!seen) begin
      $display("test %0d timed out waiting for o_checked", t);
    end
    @(negedge clk_i);
  endtask

  task automatic run_test(input int t);
    int                 base;
    int                 nx;
    int                 stall;
    logic               sent;
    logic               found;
    rvfi_pkg::mem_err_t exp_err;
    base    = t * WPT;
    nx      = words[base][23:16];
    stall   = words[base][15:8];
    exp_err = words[base][6:0];
    sent    = 1'b0;
    seen    = 1'b0;
    for (int i = 0; i < nx; i++) begin
      obi_payload = unpack_xfer(base + 2 + 4*i);
      obi_req     = 1'b1;
      obi_gnt     = 1'b0;
      // A long stall overlaps the RVFI record so the compare sees it
      for (int s = 0; s < stall; s++) begin
        if (s == 1 && stall > 2) begin
          rvfi = decode_rvfi(base);
          sent = 1'b1;
        end
        @(negedge clk_i);
        rvfi.valid = 1'b0;
      end
      obi_gnt = 1'b1;
      @(negedge clk_i);
      obi_req    = 1'b0;
      obi_gnt    = 1'b0;
      obi_rvalid = 1'b1;
      obi_rdata  = words[base + 2 + 4*i + 3];
      @(negedge clk_i);
      obi_rvalid = 1'b0;
    end
    if (!sent) begin
      rvfi = decode_rvfi(base);
      @(negedge clk_i);
      rvfi.valid = 1'b0;
    end
    wait_checked(t, found);
    if (!found) begin
      n_fail++;
      stop_run = 1'b1;
    end else if (seen_err != exp_err) begin
      $display("ERR o_err test %0d: got %h expected %h", t, seen_err, exp_err);
      n_fail++;
    end else begin
      $display("test %0d done, flags %h", t, seen_err);
      n_pass++;
    end
    repeat (2) @(negedge clk_i);
  endtask

  // Strobes and RVFI records toggle in reset, yet no output may move
  task automatic reset_test();
    int bad;
    bad = 0;
    for (int c = 0; c < 20; c++) begin
      if (c < 15) begin
        obi_req          = c[0];
        obi_gnt          = c[1];
        obi_rvalid       = c[0];
        rvfi.valid       = c[1];
        rvfi.op[0].rmask = 4'hf;
      end else begin
        rst_ni     = 1'b1;
        obi_req    = 1'b0;
        obi_gnt    = 1'b0;
        obi_rvalid = 1'b0;
        rvfi       = '0;
      end
      @(negedge clk_i);
      if (checked || err != '0) begin
        $display("ERR o_checked cycle %0d: got %h, o_err %h", c, checked, err);
        bad++;
      end
    end
    if (bad != 0) begin
      $display("reset test failed in %0d cycles", bad);
      n_fail++;
    end else begin
      $display("reset test done");
      n_pass++;
    end
  endtask

  initial begin
    rst_ni      = 1'b0;
    obi_req     = 1'b0;
    obi_gnt     = 1'b0;
    obi_rvalid  = 1'b0;
    obi_payload = '0;
    obi_rdata   = '0;
    rvfi        = '0;
    seen        = 1'b0;
    seen_err    = '0;
    stop_run    = 1'b0;
    n_pass      = 0;
    n_fail      = 0;
    $readmemh("test/mem_input.txt", words);
    // Reset spans 16 rising edges, the first at 10 ns
    @(posedge clk_i);
    @(negedge clk_i);
    reset_test();
    for (int t = 0; t < NTEST && !stop_run; t++) begin
      run_test(t);
    end
    $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* verilog/obi_pkg.sv */
// OBI data-bus package
// Holds the request payload captured from the data-side OBI port and the
// sizing of the transfer FIFO that keeps requests and responses until the
// matching instruction retires on RVFI
package obi_pkg;

  ////////////////////
  // FIFO sizing
  ////////////////////

  // Number of FIFO entries as a power of two so the pointers wrap on their own
  localparam int unsigned OBI_FIFO_DEPTH = 8;

  // Pointer width follows directly from the depth
  localparam int unsigned OBI_PTR_W = $clog2(OBI_FIFO_DEPTH);

  typedef logic [OBI_PTR_W-1:0] obi_ptr_t;

  ////////////////////
  // Request payload
  ////////////////////

  // Everything the core drives with a data request
  // The address is the word address plus the byte offset of the first byte
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [2:0]  prot;
    logic [1:0]  memtype;
    logic        dbg;
    logic        we;
  } obi_req_t;

endpackage

/* verilog/obi_xfer_fifo.sv */
// OBI transfer FIFO
// Stores every granted data request and every response in bus order and
// presents a window of consecutive entries from the read pointer onward.
// Also measures how long a request waits for its grant
module obi_xfer_fifo (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                i_req,
  input  logic                i_gnt,
  input  logic                i_rvalid,
  input  obi_pkg::obi_req_t   i_payload,
  input  logic [31:0]         i_rdata,
  input  logic [2:0]          i_consume,
  output rvfi_pkg::window_t   o_window,
  output logic                o_gnt_delay_ok
);

  // Request and response storage indexed by the same transfer number
  obi_pkg::obi_req_t  req_mem   [obi_pkg::OBI_FIFO_DEPTH];
  logic [31:0]        rdata_mem [obi_pkg::OBI_FIFO_DEPTH];

  obi_pkg::obi_ptr_t  wr_req_ptr_q;
  obi_pkg::obi_ptr_t  wr_resp_ptr_q;
  obi_pkg::obi_ptr_t  rd_ptr_q;
  rvfi_pkg::gnt_cnt_t gnt_cnt_q;
  logic               req_fire;

  // A request is taken only in a cycle with both req and gnt
  assign req_fire = i_req && i_gnt;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_mem[wr_req_ptr_q] <= i_payload;
    end
    // Responses return in request order, so they fill the same slots
    if (i_rvalid) begin
      rdata_mem[wr_resp_ptr_q] <= i_rdata;
    end
  end

  // Requests and responses each keep their own write pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_req_ptr_q  <= '0;
      wr_resp_ptr_q <= '0;
      rd_ptr_q      <= '0;
    end else begin
      if (req_fire) begin
        wr_req_ptr_q <= wr_req_ptr_q + obi_pkg::obi_ptr_t'(1);
      end
      if (i_rvalid) begin
        wr_resp_ptr_q <= wr_resp_ptr_q + obi_pkg::obi_ptr_t'(1);
      end
      // Retire the transfers used by the record compared this cycle
      rd_ptr_q <= rd_ptr_q + obi_pkg::obi_ptr_t'(i_consume);
    end
  end

  ////////////////////
  // Window
  ////////////////////

  // Consecutive entries from the read pointer wrap around the FIFO
  for (genvar k = 0; k < rvfi_pkg::WIN_SIZE; k++) begin : g_win
    obi_pkg::obi_ptr_t idx;

    assign idx               = rd_ptr_q + obi_pkg::obi_ptr_t'(k);
    assign o_window[k].req   = req_mem[idx];
    assign o_window[k].rdata = rdata_mem[idx];
  end

  ////////////////////
  // Grant stall
  ////////////////////

  // Count cycles of req without gnt and stop one step past the limit
  // The count clears as soon as the request is granted or withdrawn
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_cnt_q <= '0;
    end else if (i_req && !i_gnt) begin
      if (gnt_cnt_q <= rvfi_pkg::gnt_cnt_t'(rvfi_pkg::MAX_GNT_DLY)) begin
        gnt_cnt_q <= gnt_cnt_q + rvfi_pkg::gnt_cnt_t'(1);
      end
    end else begin
      gnt_cnt_q <= '0;
    end
  end

  // Short stalls still let the FIFO fill before the delayed record compares
  assign o_gnt_delay_ok = gnt_cnt_q <= rvfi_pkg::gnt_cnt_t'(rvfi_pkg::MAX_GNT_DLY);

endmodule

/* verilog/rvfi_mem_compare.sv */
// RVFI memory record compare
// Checks the delayed RVFI record against the record rebuilt from the OBI
// bus, field by field for each operation, and registers one error flag
// per field together with a pulse for each checked instruction
module rvfi_mem_compare (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rvfi_pkg::rvfi_mem_t i_rvfi_dly,
  input  rvfi_pkg::rvfi_mem_t i_expect,
  input  logic                i_gnt_delay_ok,
  output rvfi_pkg::mem_err_t  o_err,
  output logic                o_checked
);

  logic [rvfi_pkg::NMEM-1:0] op_rd;
  logic [rvfi_pkg::NMEM-1:0] op_wr;
  logic [rvfi_pkg::NMEM-1:0] op_wr_chk;
  logic                      ld_str_blocked;
  rvfi_pkg::mem_err_t        err_d;
  logic                      checked_d;

  // Read and write operations as reported by the core
  // Writes are only trusted when the grant stall stayed within the limit
  for (genvar g = 0; g < rvfi_pkg::NMEM; g++) begin : g_op
    assign op_rd[g]     = i_rvfi_dly.valid && (|i_rvfi_dly.op[g].rmask);
    assign op_wr[g]     = i_rvfi_dly.valid && (|i_rvfi_dly.op[g].wmask);
    assign op_wr_chk[g] = op_wr[g] && i_gnt_delay_ok;
  end

  // Load and store faults, misalignment and breakpoint or trigger entry
  // leave the read data undefined on RVFI
  assign ld_str_blocked = i_rvfi_dly.trap.trap &&
                          ((i_rvfi_dly.trap.exception &&
                            (i_rvfi_dly.trap.exception_cause inside {
                              rvfi_pkg::EXC_LOAD_MISALIGN, rvfi_pkg::EXC_LOAD_FAULT,
                              rvfi_pkg::EXC_STORE_MISALIGN, rvfi_pkg::EXC_STORE_FAULT})) ||
                           (i_rvfi_dly.trap.debug &&
                            (i_rvfi_dly.trap.debug_cause inside {
                              rvfi_pkg::DBG_CAUSE_EBREAK, rvfi_pkg::DBG_CAUSE_TRIGGER})));

  ////////////////////
  // Field compare
  ////////////////////

  always_comb begin
    rvfi_pkg::rvfi_memop_t exp_op;
    rvfi_pkg::rvfi_memop_t act_op;
    logic                  chk;
    err_d = '0;
    for (int i = 0; i < rvfi_pkg::NMEM; i++) begin
      exp_op = i_expect.op[i];
      act_op = i_rvfi_dly.op[i];
      chk    = op_rd[i] || op_wr_chk[i];
      // Address attributes are shared by reads and writes
      err_d.addr    = err_d.addr    || (chk && (exp_op.addr != act_op.addr));
      err_d.prot    = err_d.prot    || (chk && (exp_op.prot != act_op.prot));
      err_d.memtype = err_d.memtype || (chk && (exp_op.memtype != act_op.memtype));
      err_d.dbg     = err_d.dbg     || (chk && (exp_op.dbg != act_op.dbg));
      err_d.mask    = err_d.mask    ||
                      (op_rd[i] && (exp_op.rmask != act_op.rmask)) ||
                      (op_wr_chk[i] && (exp_op.wmask != act_op.wmask));
      // Data bytes outside their mask carry no meaning
      err_d.rdata   = err_d.rdata || (op_rd[i] && !ld_str_blocked &&
                      ((exp_op.rdata & rvfi_pkg::be_to_bitmask(exp_op.rmask)) !=
                       (act_op.rdata & rvfi_pkg::be_to_bitmask(act_op.rmask))));
      err_d.wdata   = err_d.wdata || (op_wr_chk[i] &&
                      ((exp_op.wdata & rvfi_pkg::be_to_bitmask(exp_op.wmask)) !=
                       (act_op.wdata & rvfi_pkg::be_to_bitmask(act_op.wmask))));
    end
  end

  // Only records that moved data count as checked
  assign checked_d = |(op_rd | op_wr);

  ////////////////////
  // Outputs
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      o_err     <= '0;
      o_checked <= 1'b0;
    end else begin
      o_err     <= err_d;
      o_checked <= checked_d;
    end
  end

endmodule

/* verilog/rvfi_mem_expect.sv */
// RVFI expected-record builder
// Delays the RVFI record so its OBI transfers can land in the FIFO, then
// rebuilds the memory record the core should have reported from the
// transfer window, for aligned and split misaligned operations
module rvfi_mem_expect (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rvfi_pkg::rvfi_mem_t i_rvfi,
  input  rvfi_pkg::window_t   i_window,
  output logic [2:0]          o_consume,
  output rvfi_pkg::rvfi_mem_t o_rvfi_dly,
  output rvfi_pkg::rvfi_mem_t o_expect
);

  // Delay line that holds the record for MAX_GNT_DLY cycles
  rvfi_pkg::rvfi_mem_t [rvfi_pkg::MAX_GNT_DLY-1:0] pipe_q;
  logic [rvfi_pkg::MAX_GNT_DLY-1:0]                vld_q;

  rvfi_pkg::rvfi_mem_t       rvfi_dly;
  logic [rvfi_pkg::NMEM-1:0] op_rd;
  logic [rvfi_pkg::NMEM-1:0] op_wr;
  logic [2:0]                num_op;
  logic                      split;

  // A first byte offset plus the enabled bytes past the word end means two transfers
  function automatic logic split_xfer(input logic [1:0] addr_lsb, input logic [3:0] mask);
    return (int'(addr_lsb) + $countones(mask)) > 4;
  endfunction

  // Rebuild one operation from its first and (when split) second transfer
  function automatic rvfi_pkg::rvfi_memop_t build_op(input rvfi_pkg::xfer_t e0,
                                                     input rvfi_pkg::xfer_t e1,
                                                     input logic is_split,
                                                     input logic rd,
                                                     input logic wr);
    rvfi_pkg::rvfi_memop_t op;
    logic [1:0]            offs;
    logic [2:0]            shift2;
    logic [3:0]            mask;
    logic [31:0]           wdata;
    logic [31:0]           rdata;
    op     = '0;
    offs   = e0.req.addr[1:0];
    shift2 = 3'd4 - {1'b0, offs};
    // First transfer moves down by its byte offset
    mask  = e0.req.be >> offs;
    wdata = (e0.req.wdata & rvfi_pkg::be_to_bitmask(e0.req.be)) >> {offs, 3'b000};
    rdata = (e0.rdata & rvfi_pkg::be_to_bitmask(e0.req.be)) >> {offs, 3'b000};
    // The second transfer supplies the upper bytes from address zero of the next word
    if (is_split) begin
      mask  = mask | (e1.req.be << shift2);
      wdata = wdata | ((e1.req.wdata & rvfi_pkg::be_to_bitmask(e1.req.be)) << {shift2, 3'b000});
      rdata = rdata | ((e1.rdata & rvfi_pkg::be_to_bitmask(e1.req.be)) << {shift2, 3'b000});
    end
    if (rd || wr) begin
      // Both halves of a split share address attributes, so the first entry wins
      op.addr    = e0.req.addr;
      op.prot    = e0.req.prot;
      op.memtype = e0.req.memtype;
      op.dbg     = e0.req.dbg;
      op.wdata   = wdata;
      op.rdata   = rdata;
      // A bus direction that disagrees with RVFI leaves the mask at zero
      op.rmask   = (rd && !e0.req.we) ? mask : 4'b0000;
      op.wmask   = (wr && e0.req.we) ? mask : 4'b0000;
    end
    return op;
  endfunction

  ////////////////////
  // Record delay
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= i_rvfi.valid;
      for (int k = 1; k < rvfi_pkg::MAX_GNT_DLY; k++) begin
        vld_q[k] <= vld_q[k-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pipe_q[0] <= i_rvfi;
    for (int k = 1; k < rvfi_pkg::MAX_GNT_DLY; k++) begin
      pipe_q[k] <= pipe_q[k-1];
    end
  end

  always_comb begin
    rvfi_dly       = pipe_q[rvfi_pkg::MAX_GNT_DLY-1];
    rvfi_dly.valid = vld_q[rvfi_pkg::MAX_GNT_DLY-1];
  end

  assign o_rvfi_dly = rvfi_dly;

  ////////////////////
  // Expected record
  ////////////////////

  // An operation is active when its read or write mask has a byte set
  always_comb begin
    num_op = 3'd0;
    for (int i = 0; i < rvfi_pkg::NMEM; i++) begin
      op_rd[i] = rvfi_dly.valid && (|rvfi_dly.op[i].rmask);
      op_wr[i] = rvfi_dly.valid && (|rvfi_dly.op[i].wmask);
      if (op_rd[i] || op_wr[i]) begin
        num_op = num_op + 3'd1;
      end
    end
  end

  // Operation 0 decides for the whole instruction since multi-op accesses are all words
  assign split = split_xfer(rvfi_dly.op[0].addr[1:0],
                            rvfi_dly.op[0].rmask | rvfi_dly.op[0].wmask);

  // Split operations retire two transfers each
  assign o_consume = split ? {num_op[1:0], 1'b0} : num_op;

  always_comb begin
    int base;
    o_expect       = '0;
    o_expect.valid = rvfi_dly.valid;
    o_expect.trap  = rvfi_dly.trap;
    for (int i = 0; i < rvfi_pkg::NMEM; i++) begin
      base           = split ? 2 * i : i;
      o_expect.op[i] = build_op(i_window[base], i_window[base+1], split, op_rd[i], op_wr[i]);
    end
  end

endmodule

/* verilog/rvfi_mem_monitor.sv */
// RVFI memory monitor
// Observes the OBI data bus and the RVFI memory record of a RISC-V core and
// flags every field of a retired memory operation that the bus disagrees with.
// Flags appear three cycles after the RVFI valid cycle
module rvfi_mem_monitor (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                i_obi_req,
  input  logic                i_obi_gnt,
  input  logic                i_obi_rvalid,
  input  obi_pkg::obi_req_t   i_obi_payload,
  input  logic [31:0]         i_obi_rdata,
  input  rvfi_pkg::rvfi_mem_t i_rvfi,
  output rvfi_pkg::mem_err_t  o_err,
  output logic                o_checked
);

  rvfi_pkg::window_t   window;
  logic                gnt_delay_ok;
  logic [2:0]          consume;
  rvfi_pkg::rvfi_mem_t rvfi_dly;
  rvfi_pkg::rvfi_mem_t rvfi_exp;

  // The FIFO captures the bus and retires transfers as records are compared
  obi_xfer_fifo u_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_req          (i_obi_req),
    .i_gnt          (i_obi_gnt),
    .i_rvalid       (i_obi_rvalid),
    .i_payload      (i_obi_payload),
    .i_rdata        (i_obi_rdata),
    .i_consume      (consume),
    .o_window       (window),
    .o_gnt_delay_ok (gnt_delay_ok)
  );

  rvfi_mem_expect u_expect (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .i_rvfi     (i_rvfi),
    .i_window   (window),
    .o_consume  (consume),
    .o_rvfi_dly (rvfi_dly),
    .o_expect   (rvfi_exp)
  );

  rvfi_mem_compare u_compare (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_rvfi_dly     (rvfi_dly),
    .i_expect       (rvfi_exp),
    .i_gnt_delay_ok (gnt_delay_ok),
    .o_err          (o_err),
    .o_checked      (o_checked)
  );

endmodule

/* verilog/rvfi_pkg.sv */
// RVFI memory package
// Describes the retired-instruction memory record, one entry of the OBI
// transfer window, the per-field error flags and the record delay
package rvfi_pkg;

  // Memory operations reported per retired instruction
  localparam int unsigned NMEM = 2;

  // Cycles the RVFI record waits for its OBI transfers and the grant-stall limit
  localparam int unsigned MAX_GNT_DLY = 2;

  // Stall counter saturates one step past the limit
  localparam int unsigned GNT_CNT_W = $clog2(MAX_GNT_DLY + 2);
  typedef logic [GNT_CNT_W-1:0] gnt_cnt_t;

  // A split operation uses two transfers, so the window covers twice NMEM
  localparam int unsigned WIN_SIZE = 2 * NMEM;

  // Exception and debug causes that block the load or store data
  localparam logic [5:0] EXC_LOAD_MISALIGN  = 6'h4;
  localparam logic [5:0] EXC_LOAD_FAULT     = 6'h5;
  localparam logic [5:0] EXC_STORE_MISALIGN = 6'h6;
  localparam logic [5:0] EXC_STORE_FAULT    = 6'h7;
  localparam logic [2:0] DBG_CAUSE_EBREAK   = 3'h1;
  localparam logic [2:0] DBG_CAUSE_TRIGGER  = 3'h2;

  ////////////////////
  // RVFI record
  ////////////////////

  // One memory operation with data and masks in RVFI alignment
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [2:0]  prot;
    logic [1:0]  memtype;
    logic        dbg;
  } rvfi_memop_t;

  typedef struct packed {
    logic       trap;
    logic       exception;
    logic [5:0] exception_cause;
    logic       debug;
    logic [2:0] debug_cause;
  } rvfi_trap_t;

  typedef struct packed {
    logic                   valid;
    rvfi_trap_t             trap;
    rvfi_memop_t [NMEM-1:0] op;
  } rvfi_mem_t;

  // One flag per checked field ORed over all operations
  typedef struct packed {
    logic addr;
    logic mask;
    logic rdata;
    logic wdata;
    logic prot;
    logic memtype;
    logic dbg;
  } mem_err_t;

  ////////////////////
  // Transfer window
  ////////////////////

  // A granted request together with the read data of its response
  typedef struct packed {
    obi_pkg::obi_req_t req;
    logic [31:0]       rdata;
  } xfer_t;

  // Entry 0 sits at the FIFO read pointer
  typedef xfer_t [WIN_SIZE-1:0] window_t;

  // Expand byte enables to a bit mask over the data word
  function automatic logic [31:0] be_to_bitmask(input logic [3:0] be);
    logic [31:0] bm;
    for (int b = 0; b < 4; b++) begin
      bm[8*b +: 8] = {8{be[b]}};
    end
    return bm;
  endfunction

endpackage
